// ==== all.f ====
design/mbus_pkg.sv
design/mbus_router.sv
design/mbus_ram_dev.sv
design/mbus_reg_dev.sv
design/mbus_subsys_top.sv
dv/tb_clkgen.sv
dv/tb_mbus_subsys.sv

// ==== Bender.yml ====
package:
  name: mbus_subsys

sources:
  - design/mbus_pkg.sv
  - design/mbus_router.sv
  - design/mbus_ram_dev.sv
  - design/mbus_reg_dev.sv
  - design/mbus_subsys_top.sv
  - target: simulation
    files:
      - dv/tb_clkgen.sv
      - dv/tb_mbus_subsys.sv

// ==== dv/tb_mbus_subsys.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-bus subsystem testbench
// Table-driven master, in-order response checker,
// random response back-pressure and a cycle timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_mbus_subsys;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NBUS        = 2;
   localparam int RAM_AW      = 6;
   localparam int NTAB        = 25;
   // Back-to-back RAM section with rsp_ready held high
   localparam int FINAL_START = 20;
   localparam int TIMEOUT_CYC = 40 * NTAB;
   localparam int DRV_DLY     = 1;

   logic                clk;
   logic                rst_n;
   logic                cmd_valid;
   logic                cmd_ready;
   mbus_pkg::mbus_cmd_t cmd;
   logic                rsp_valid;
   logic                rsp_ready;
   mbus_pkg::mbus_rsp_t rsp;

   // Stimulus table and expected response words
   mbus_pkg::addr_t addr_tab  [NTAB];
   mbus_pkg::wmsk_t msk_tab   [NTAB];
   mbus_pkg::data_t wdata_tab [NTAB];
   mbus_pkg::data_t exp_tab   [NTAB];
   int              cmd_cycle [NTAB];

   int              n_fill     = 0;
   int              cmd_cnt    = 0;
   int              rsp_cnt    = 0;
   int              cycle      = 0;
   int              errors     = 0;
   logic            hold_prev  = 1'b0;
   mbus_pkg::data_t prev_rsp   = '0;
   logic [31:0]     rnd        = 32'h5818_845d;

   tb_clkgen #(
      .PERIOD     (8),
      .RST_CYCLES (5)
   ) clkgen_i (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mbus_subsys_top #(
      .NBUS   (NBUS),
      .RAM_AW (RAM_AW)
   ) dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd       (cmd),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic mbus_pkg::region_t entry_region(input int k);
      return addr_tab[k][mbus_pkg::REGION_LSB +: 4];
   endfunction

   task automatic add_entry(input mbus_pkg::addr_t a, input mbus_pkg::wmsk_t m,
                            input mbus_pkg::data_t d, input mbus_pkg::data_t e);
      addr_tab[n_fill]  = a;
      msk_tab[n_fill]   = m;
      wdata_tab[n_fill] = d;
      exp_tab[n_fill]   = e;
      n_fill++;
   endtask

   task automatic load_table();
      // RAM full and partial masks with word 0 aliased at 0x100
      add_entry(32'h0000_0000, 4'hF, 32'h1122_3344, 32'h0000_0000);
      add_entry(32'h0000_0004, 4'hF, 32'hAABB_CCDD, 32'h0000_0000);
      add_entry(32'h0000_0000, 4'h5, 32'hEEFF_0099, 32'h0000_0000);
      add_entry(32'h0000_0000, 4'h0, 32'h0000_0000, 32'h11FF_3399);
      add_entry(32'h0000_0004, 4'hA, 32'h5566_7788, 32'h0000_0000);
      add_entry(32'h0000_0004, 4'h0, 32'h0000_0000, 32'h55BB_77DD);
      add_entry(32'h0000_0100, 4'h0, 32'h0000_0000, 32'h11FF_3399);
      // Register device with the counter after each region 1 command
      add_entry(32'h1000_0000, 4'hF, 32'hCAFE_F00D, 32'hCAFE_F00D);
      add_entry(32'h1000_0000, 4'h0, 32'h0000_0000, 32'hCAFE_F00D);
      add_entry(32'h1000_0000, 4'h3, 32'h0000_1234, 32'hCAFE_1234);
      add_entry(32'h1000_0004, 4'h0, 32'h0000_0000, 32'h0000_0004);
      add_entry(32'h1000_0008, 4'h0, 32'h0000_0000, mbus_pkg::REG_ID);
      // Unmapped regions 2 and 15
      add_entry(32'h2000_0000, 4'h0, 32'h0000_0000, mbus_pkg::ERR_DATA);
      add_entry(32'hF000_0010, 4'hF, 32'h0000_0001, mbus_pkg::ERR_DATA);
      add_entry(32'h1000_0004, 4'h0, 32'h0000_0000, 32'h0000_0006);
      // RAM and register device alternating
      add_entry(32'h0000_0004, 4'h0, 32'h0000_0000, 32'h55BB_77DD);
      add_entry(32'h1000_0000, 4'h0, 32'h0000_0000, 32'hCAFE_1234);
      add_entry(32'h0000_0008, 4'hF, 32'h0BAD_F00D, 32'h0000_0000);
      add_entry(32'h1000_0004, 4'h0, 32'h0000_0000, 32'h0000_0008);
      add_entry(32'h0000_0008, 4'h0, 32'h0000_0000, 32'h0BAD_F00D);
      // Back-to-back RAM
      add_entry(32'h0000_000C, 4'hF, 32'h600D_CAFE, 32'h0000_0000);
      add_entry(32'h0000_000C, 4'h0, 32'h0000_0000, 32'h600D_CAFE);
      add_entry(32'h0000_000C, 4'hC, 32'h1234_0000, 32'h0000_0000);
      add_entry(32'h0000_000C, 4'h0, 32'h0000_0000, 32'h1234_CAFE);
      add_entry(32'h0000_0000, 4'h0, 32'h0000_0000, 32'h11FF_3399);
   endtask

   // Held response must stay valid and unchanged
   task automatic check_stable();
      if (hold_prev) begin
         if (!rsp_valid) begin
            $display("rsp_valid dropped while rsp_ready was low");
            errors++;
         end else if (rsp.rdata !== prev_rsp) begin
            $display("[FAIL] rsp.rdata changed under back-pressure: got %h, held %h",
                     rsp.rdata, prev_rsp);
            errors++;
         end
      end
      hold_prev = rsp_valid & ~rsp_ready;
      prev_rsp  = rsp.rdata;
   endtask

   // Exactly one table entry outstanding while a response is valid
   task automatic check_owner();
      if (rsp_valid) begin
         if (cmd_cnt <= rsp_cnt) begin
            $display("rsp_valid high with no command outstanding");
            errors++;
         end else if (cmd_cnt - rsp_cnt > 1) begin
            $display("%0d commands outstanding at once", cmd_cnt - rsp_cnt);
            errors++;
         end
      end
   endtask

   task automatic take_cmd();
      if (cmd_cnt >= NTAB) begin
         $display("command transfer beyond the end of the table");
         errors++;
      end else begin
         // New command joins only the bus that owns the path
         if (cmd_cnt > rsp_cnt) begin
            if (entry_region(cmd_cnt) >= NBUS ||
                entry_region(cmd_cnt) != entry_region(rsp_cnt)) begin
               $display("command to region %0d accepted while region %0d is outstanding",
                        entry_region(cmd_cnt), entry_region(rsp_cnt));
               errors++;
            end
         end
         cmd_cycle[cmd_cnt] = cycle;
         cmd_cnt++;
      end
   endtask

   task automatic take_rsp(input int sent);
      if (rsp_cnt >= sent) begin
         $display("response transfer with no command outstanding");
         errors++;
      end else begin
         if (rsp.rdata !== exp_tab[rsp_cnt]) begin
            $display("[FAIL] rsp.rdata entry %0d: got %h, expected %h",
                     rsp_cnt, rsp.rdata, exp_tab[rsp_cnt]);
            errors++;
         end
         if (rsp_cnt >= FINAL_START && cycle - cmd_cycle[rsp_cnt] != 1) begin
            $display("response for entry %0d came %0d cycles after its command, expected 1",
                     rsp_cnt, cycle - cmd_cycle[rsp_cnt]);
            errors++;
         end
         rsp_cnt++;
      end
   endtask

   // Monitor samples at the edge before any DUT update
   always @(posedge clk) begin : monitor
      int sent;
      cycle++;
      sent = cmd_cnt;
      if (rst_n) begin
         check_stable();
         check_owner();
         if (cmd_valid && cmd_ready) begin
            take_cmd();
         end
         if (rsp_valid && rsp_ready) begin
            take_rsp(sent);
         end
      end
   end

   // Random rsp_ready low about one cycle in four
   // Held high once the final RAM section is being sent
   initial begin
      rsp_ready = 1'b0;
      wait (rst_n);
      forever begin
         @(posedge clk);
         #DRV_DLY;
         rnd = xorshift32(rnd);
         rsp_ready = (cmd_cnt >= FINAL_START) | (rnd[1:0] != 2'b00);
      end
   end

   // Table driver and end of run
   initial begin
      cmd_valid = 1'b0;
      cmd       = '0;
      load_table();
      wait (rst_n);
      @(posedge clk);
      if (rsp_valid) begin
         $display("rsp_valid high right after reset");
         errors++;
      end
      #DRV_DLY;
      for (int k = 0; k < NTAB; k++) begin
         cmd_valid  = 1'b1;
         cmd.addr   = addr_tab[k];
         cmd.we_msk = msk_tab[k];
         cmd.wdata  = wdata_tab[k];
         @(posedge clk);
         while (!cmd_ready) begin
            @(posedge clk);
         end
         #DRV_DLY;
      end
      cmd_valid = 1'b0;
      cmd       = '0;
      wait (rsp_cnt == NTAB);
      // A few idle cycles to catch stray responses
      repeat (4) @(posedge clk);
      $display("Run done: %0d responses checked, %0d errors", rsp_cnt, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Cycle limit from the table length
   initial begin
      repeat (TIMEOUT_CYC) @(posedge clk);
      $display("Timeout after %0d cycles with %0d of %0d responses received",
               TIMEOUT_CYC, rsp_cnt, NTAB);
      $display("Run done: %0d responses checked, %0d errors", rsp_cnt, errors);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator
// Free-running clock, synchronous active-low reset pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD     = 8,
   parameter int RST_CYCLES = 5
) (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Release just after an edge, like the other inputs
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== design/mbus_subsys_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-bus subsystem top
// Router with RAM on bus 0 and register device on bus 1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mbus_subsys_top #(
   parameter int NBUS   = 2,
   parameter int RAM_AW = 6
) (
   input  wire logic                clk,
   input  wire logic                rst_n,
   // Master command
   input  wire logic                cmd_valid,
   output wire logic                cmd_ready,
   input  wire mbus_pkg::mbus_cmd_t cmd,
   // Master response
   output wire logic                rsp_valid,
   input  wire logic                rsp_ready,
   output mbus_pkg::mbus_rsp_t      rsp
);

   // Per-bus channels between router and devices
   logic [NBUS-1:0]                 bus_cmd_valid;
   logic [NBUS-1:0]                 bus_cmd_ready;
   mbus_pkg::mbus_cmd_t             bus_cmd;
   logic [NBUS-1:0]                 bus_rsp_valid;
   logic [NBUS-1:0]                 bus_rsp_ready;
   mbus_pkg::mbus_rsp_t [NBUS-1:0]  bus_rsp;

   mbus_router #(
      .NBUS (NBUS)
   ) router_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .cmd_valid     (cmd_valid),
      .cmd_ready     (cmd_ready),
      .cmd           (cmd),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .rsp           (rsp),
      .bus_cmd_valid (bus_cmd_valid),
      .bus_cmd_ready (bus_cmd_ready),
      .bus_cmd       (bus_cmd),
      .bus_rsp_valid (bus_rsp_valid),
      .bus_rsp_ready (bus_rsp_ready),
      .bus_rsp       (bus_rsp)
   );

   // Region 0
   mbus_ram_dev #(
      .RAM_AW (RAM_AW)
   ) ram_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (bus_cmd_valid[0]),
      .cmd_ready (bus_cmd_ready[0]),
      .cmd       (bus_cmd),
      .rsp_valid (bus_rsp_valid[0]),
      .rsp_ready (bus_rsp_ready[0]),
      .rsp       (bus_rsp[0])
   );

   // Region 1
   mbus_reg_dev reg_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (bus_cmd_valid[1]),
      .cmd_ready (bus_cmd_ready[1]),
      .cmd       (bus_cmd),
      .rsp_valid (bus_rsp_valid[1]),
      .rsp_ready (bus_rsp_ready[1]),
      .rsp       (bus_rsp[1])
   );

endmodule

`default_nettype wire

// ==== design/mbus_reg_dev.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register device
// Scratch register, access counter and identifier word,
// answered after a fixed two-cycle wait
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mbus_reg_dev (
   input  wire logic                clk,
   input  wire logic                rst_n,
   // Command channel
   input  wire logic                cmd_valid,
   output logic                     cmd_ready,
   input  wire mbus_pkg::mbus_cmd_t cmd,
   // Response channel
   output logic                     rsp_valid,
   input  wire logic                rsp_ready,
   output mbus_pkg::mbus_rsp_t      rsp
);

   localparam int OFF_W = mbus_pkg::REGION_LSB - 2;
   localparam int NBYTE = $bits(mbus_pkg::wmsk_t);

   mbus_pkg::reg_dev_state_t state;
   logic                     wait_last;
   logic                     cmd_fire;
   logic [OFF_W-1:0]         off;
   mbus_pkg::data_t          scratch;
   mbus_pkg::data_t          scratch_new;
   mbus_pkg::data_t          count;
   mbus_pkg::data_t          count_new;
   mbus_pkg::data_t          rsp_data;

   // Word offset within the region
   assign off = cmd.addr[mbus_pkg::REGION_LSB-1:2];

   // One command at a time
   assign cmd_ready = (state == mbus_pkg::IDLE);
   assign cmd_fire  = cmd_valid & cmd_ready;

   // Counter includes the command being taken
   assign count_new = count + 1'b1;

   // Scratch merged with the masked write bytes
   always_comb begin
      scratch_new = scratch;
      for (int b = 0; b < NBYTE; b++) begin
         if (cmd.we_msk[b]) begin
            scratch_new[8*b +: 8] = cmd.wdata[8*b +: 8];
         end
      end
   end

   // Register state
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         scratch <= '0;
         count   <= '0;
      end else if (cmd_fire) begin
         count <= count_new;
         if (off == OFF_W'(0)) begin
            scratch <= scratch_new;
         end
      end
   end

   // Read value captured at accept, value after any write
   always_ff @(posedge clk) begin
      if (cmd_fire) begin
         case (off)
            OFF_W'(0): rsp_data <= scratch_new;
            OFF_W'(1): rsp_data <= count_new;
            OFF_W'(2): rsp_data <= mbus_pkg::REG_ID;
            default:   rsp_data <= '0;
         endcase
      end
   end

   // FSM, IDLE -> two WAIT cycles -> RESP until taken
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= mbus_pkg::IDLE;
         wait_last <= 1'b0;
      end else begin
         case (state)
            mbus_pkg::IDLE: begin
               if (cmd_fire) begin
                  state     <= mbus_pkg::WAIT;
                  wait_last <= 1'b0;
               end
            end
            mbus_pkg::WAIT: begin
               wait_last <= 1'b1;
               if (wait_last) begin
                  state <= mbus_pkg::RESP;
               end
            end
            mbus_pkg::RESP: begin
               if (rsp_ready) begin
                  state <= mbus_pkg::IDLE;
               end
            end
            default: state <= mbus_pkg::IDLE;
         endcase
      end
   end

   assign rsp_valid = (state == mbus_pkg::RESP);
   assign rsp.rdata = rsp_data;

endmodule

`default_nettype wire

// ==== design/mbus_ram_dev.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word RAM device
// Byte-masked writes, one-entry response register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mbus_ram_dev #(
   parameter int RAM_AW = 6
) (
   input  wire logic                clk,
   input  wire logic                rst_n,
   // Command channel
   input  wire logic                cmd_valid,
   output logic                     cmd_ready,
   input  wire mbus_pkg::mbus_cmd_t cmd,
   // Response channel
   output logic                     rsp_valid,
   input  wire logic                rsp_ready,
   output mbus_pkg::mbus_rsp_t      rsp
);

   localparam int DEPTH = 2 ** RAM_AW;
   localparam int NBYTE = $bits(mbus_pkg::wmsk_t);

   mbus_pkg::data_t   mem [DEPTH];
   logic [RAM_AW-1:0] idx;
   logic              cmd_fire;
   logic              is_write;
   mbus_pkg::data_t   rsp_data;

   // Word index, upper bits inside the region ignored
   assign idx = cmd.addr[RAM_AW+1:2];

   assign is_write = |cmd.we_msk;

   // Free slot, or the held response leaves this cycle
   assign cmd_ready = ~rsp_valid | rsp_ready;
   assign cmd_fire  = cmd_valid & cmd_ready;

   // Storage array
   // Per-byte enables
   always_ff @(posedge clk) begin
      if (cmd_fire) begin
         for (int b = 0; b < NBYTE; b++) begin
            if (cmd.we_msk[b]) begin
               mem[idx][8*b +: 8] <= cmd.wdata[8*b +: 8];
            end
         end
      end
   end

   // Response payload, loaded on accept and held otherwise
   always_ff @(posedge clk) begin
      if (cmd_fire) begin
         // Writes answer zero, reads the old word
         rsp_data <= is_write ? '0 : mem[idx];
      end
   end

   // Response valid flag
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else if (cmd_fire) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   assign rsp.rdata = rsp_data;

endmodule

`default_nettype wire

// ==== design/mbus_router.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-bus command/response router
// Decodes the region, lets one bus own the response path,
// merges responses and answers unmapped regions itself
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mbus_router #(
   parameter int NBUS = 2
) (
   input  wire logic                              clk,
   input  wire logic                              rst_n,
   // Master side
   input  wire logic                              cmd_valid,
   output logic                                   cmd_ready,
   input  wire mbus_pkg::mbus_cmd_t               cmd,
   output logic                                   rsp_valid,
   input  wire logic                              rsp_ready,
   output mbus_pkg::mbus_rsp_t                    rsp,
   // Device side
   output logic                [NBUS-1:0]         bus_cmd_valid,
   input  wire logic           [NBUS-1:0]         bus_cmd_ready,
   output mbus_pkg::mbus_cmd_t                    bus_cmd,
   input  wire logic           [NBUS-1:0]         bus_rsp_valid,
   output logic                [NBUS-1:0]         bus_rsp_ready,
   input  wire mbus_pkg::mbus_rsp_t [NBUS-1:0]    bus_rsp
);

   mbus_pkg::region_t region;
   logic [NBUS-1:0]   sel;
   logic              mapped;
   logic [NBUS-1:0]   pending;
   logic [NBUS-1:0]   accept;
   logic [NBUS-1:0]   cmd_fire;
   logic [NBUS-1:0]   rsp_fire;
   logic              err_valid;
   logic              err_ready;
   logic              err_fire;
   logic              idle;

   // Region field of the incoming command
   assign region = cmd.addr[mbus_pkg::REGION_LSB +: $bits(mbus_pkg::region_t)];

   // One-hot bus select, all zero when unmapped
   always_comb begin
      for (int i = 0; i < NBUS; i++) begin
         sel[i] = (region == mbus_pkg::region_t'(i));
      end
   end

   assign mapped = (region < mbus_pkg::region_t'(NBUS));

   // Nothing outstanding anywhere
   assign idle = ~|pending & ~err_valid;

   // Bus may take a command when free or already owning the slot
   // Error response in flight blocks everyone to keep order
   always_comb begin
      for (int i = 0; i < NBUS; i++) begin
         accept[i] = ~err_valid & (~|pending | pending[i]);
      end
   end

   // Command broadcast, valid only to the selected bus
   assign bus_cmd       = cmd;
   assign bus_cmd_valid = {NBUS{cmd_valid}} & sel & accept;
   assign cmd_fire      = bus_cmd_valid & bus_cmd_ready;

   // Error responder takes unmapped commands when all is drained
   assign err_ready = ~mapped & idle;
   assign err_fire  = cmd_valid & err_ready;

   assign cmd_ready = |(sel & accept & bus_cmd_ready) | err_ready;

   // Only the owning bus sees the master's ready
   assign bus_rsp_ready = {NBUS{rsp_ready}} & pending;
   assign rsp_fire      = bus_rsp_valid & bus_rsp_ready;

   assign rsp_valid = |(pending & bus_rsp_valid) | err_valid;

   // Response mux as an OR of pending buses
   // at most one source is live at a time
   always_comb begin
      rsp.rdata = err_valid ? mbus_pkg::ERR_DATA : '0;
      for (int i = 0; i < NBUS; i++) begin
         if (pending[i]) begin
            rsp.rdata = rsp.rdata | bus_rsp[i].rdata;
         end
      end
   end

   // Per-bus pending bits and the error entry
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending   <= '0;
         err_valid <= 1'b0;
      end else begin
         // Set on command, clear on response
         pending <= cmd_fire | (pending & ~rsp_fire);
         if (err_fire) begin
            err_valid <= 1'b1;
         end else if (rsp_ready) begin
            err_valid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/mbus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-bus package
// Bus vector types, command and response payloads, region
// field position and the fixed words of the subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mbus_pkg;

   // Byte address and data word
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;

   // One bit per byte lane, all zero is a read
   typedef logic [3:0] wmsk_t;

   // Region number from the top address bits
   typedef logic [3:0] region_t;

   // Region field sits at bits 31:28
   localparam int REGION_LSB = 28;

   // Answer for commands that hit no device
   localparam data_t ERR_DATA = 32'hDEAD_0BAD;

   // Identifier of the register device
   localparam data_t REG_ID = 32'h4D42_0001;

   // Command payload, shared by master and all buses
   typedef struct packed {
      addr_t addr;
      wmsk_t we_msk;
      data_t wdata;
   } mbus_cmd_t;

   // Response payload
   typedef struct packed {
      data_t rdata;
   } mbus_rsp_t;

   // Register device FSM
   typedef enum logic [1:0] {
      IDLE,
      WAIT,
      RESP
   } reg_dev_state_t;

endpackage

`default_nettype wire
